//--- logic/core_pkg.sv
package core_pkg;

    // datapath widths
    localparam int data_w = 32;
    localparam int reg_w  = 4;
    localparam int pc_w   = 32;

    // architectural register file size, register 0 reads zero
    localparam int num_regs = 1 << reg_w;

    // multiply pipeline depth in exec
    localparam int mul_stages = 3;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_mul,
        op_store,
        op_branch
    } opcode_t;

    // decoded instruction with operand values already resolved
    typedef struct packed {
        opcode_t           op;
        logic [reg_w-1:0]  rd;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [pc_w-1:0]   pc;
        logic [pc_w-1:0]   target;
        logic              pred_taken;
    } instr_t;

    // ops that write a destination register at retire
    function automatic logic is_arith(input opcode_t op);
        return (op == op_add) || (op == op_sub) || (op == op_xor) || (op == op_mul);
    endfunction

    // ops that take the long multiply path
    function automatic logic is_mul(input opcode_t op);
        return op == op_mul;
    endfunction

endpackage

//--- logic/rob_pkg.sv
package rob_pkg;

    import core_pkg::*;

    localparam int rob_depth = 16;
    localparam int tag_w     = $clog2(rob_depth);
    // one extra bit so a full buffer is distinguishable from empty
    localparam int cnt_w     = tag_w + 1;

    typedef logic [tag_w-1:0] rob_tag_t;

    // dispatch to exec
    typedef struct packed {
        instr_t   instr;
        rob_tag_t tag;
    } issue_t;

    // exec to rob, one per completion port
    typedef struct packed {
        rob_tag_t          tag;
        logic [data_w-1:0] result;
        logic              actual_taken;
        logic [pc_w-1:0]   next_pc;
    } complete_t;

    // dispatch to rob at allocation
    typedef struct packed {
        rob_tag_t         tag;
        opcode_t          op;
        logic [reg_w-1:0] rd;
        logic             pred_taken;
    } alloc_t;

    // one buffer slot, also what the head presents to retire
    typedef struct packed {
        opcode_t           op;
        logic [reg_w-1:0]  rd;
        logic [data_w-1:0] result;
        logic              pred_taken;
        logic              actual_taken;
        logic [pc_w-1:0]   next_pc;
        logic              done;
    } rob_entry_t;

endpackage

//--- logic/dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit
    import core_pkg::*;
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  instr_t   in_instr,
    input  logic     full,
    input  logic     flush,
    output logic     alloc_en,
    output alloc_t   alloc,
    output logic     issue_en,
    output issue_t   issue
);

    // next tag to hand out, follows the rob tail
    rob_tag_t tail;
    logic     accept;

    // strobes that arrive while full are dropped, the source holds them
    assign accept   = in_valid && !full;
    assign alloc_en = accept;

    always_comb begin
        alloc.tag        = tail;
        alloc.op         = in_instr.op;
        alloc.rd         = in_instr.rd;
        alloc.pred_taken = in_instr.pred_taken;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tail     <= '0;
            issue_en <= 1'b0;
        end else if (flush) begin
            // rob restarts at slot 0 after a clear
            tail     <= '0;
            issue_en <= 1'b0;
        end else begin
            issue_en <= accept;
            if (accept) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // issue packet, registered on the same edge as allocation
    always_ff @(posedge clk) begin
        if (accept) begin
            issue.instr <= in_instr;
            issue.tag   <= tail;
        end
    end

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import core_pkg::*;
    import rob_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      issue_en,
    input  issue_t    issue,
    output logic      alu_done_en,
    output complete_t alu_done,
    output logic      mul_done_en,
    output complete_t mul_done
);

    typedef struct packed {
        rob_tag_t          tag;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
    } mul_ops_t;

    complete_t         alu_res;
    logic              alu_go;
    logic              mul_go;
    logic              taken;
    logic [pc_w-1:0]   seq_pc;

    // multiply pipe, one valid bit per stage
    logic [mul_stages-1:0] mul_valid;
    mul_ops_t              mul_s1;
    complete_t             mul_s2;

    assign alu_go = issue_en && !is_mul(issue.instr.op);
    assign mul_go = issue_en && is_mul(issue.instr.op);

    // branch resolves as taken when the operands compare equal
    assign taken  = (issue.instr.op == op_branch) && (issue.instr.a == issue.instr.b);
    assign seq_pc = issue.instr.pc + pc_w'(4);

    always_comb begin
        alu_res.tag          = issue.tag;
        alu_res.actual_taken = taken;
        alu_res.next_pc      = taken ? issue.instr.target : seq_pc;
        case (issue.instr.op)
            op_add:   alu_res.result = issue.instr.a + issue.instr.b;
            op_sub:   alu_res.result = issue.instr.a - issue.instr.b;
            op_xor:   alu_res.result = issue.instr.a ^ issue.instr.b;
            // store carries its data in a
            op_store: alu_res.result = issue.instr.a;
            default:  alu_res.result = '0;
        endcase
    end

    // valids, killed by flush
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            alu_done_en <= 1'b0;
            mul_valid   <= '0;
        end else begin
            alu_done_en <= alu_go;
            mul_valid   <= {mul_valid[mul_stages-2:0], mul_go};
        end
    end

    assign mul_done_en = mul_valid[mul_stages-1];

    // payload stages
    always_ff @(posedge clk) begin
        if (alu_go) begin
            alu_done <= alu_res;
        end
        if (mul_go) begin
            mul_s1.tag <= issue.tag;
            mul_s1.a   <= issue.instr.a;
            mul_s1.b   <= issue.instr.b;
        end
        if (mul_valid[0]) begin
            mul_s2.tag          <= mul_s1.tag;
            mul_s2.result       <= mul_s1.a * mul_s1.b;
            mul_s2.actual_taken <= 1'b0;
            mul_s2.next_pc      <= '0;
        end
        if (mul_valid[1]) begin
            mul_done <= mul_s2;
        end
    end

    // tags are unique while in flight, so the two ports never collide
    a_ports_distinct: assert property (
        @(posedge clk) disable iff (reset)
        (alu_done_en && mul_done_en) |-> (alu_done.tag != mul_done.tag)
    );

endmodule

//--- logic/rob.sv
`timescale 1ns/1ps

module rob
    import core_pkg::*;
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       alloc_en,
    input  alloc_t     alloc,
    input  logic       alu_done_en,
    input  complete_t  alu_done,
    input  logic       mul_done_en,
    input  complete_t  mul_done,
    input  logic       head_release,
    output logic       full,
    output logic       head_valid,
    output rob_entry_t head
);

    rob_entry_t entries [rob_depth];

    rob_tag_t           head_ptr;
    logic [cnt_w-1:0]   count;
    logic [cnt_w-1:0]   count_next;

    // slot is live if it sits within count of the head
    function automatic logic occupied(input rob_tag_t tag, input rob_tag_t hp,
                                      input logic [cnt_w-1:0] cnt);
        rob_tag_t offset;
        offset = tag - hp;
        return {1'b0, offset} < cnt;
    endfunction

    assign head_valid = (count != '0);
    assign head       = entries[head_ptr];

    // held high during a flush so nothing is allocated into a buffer about to clear
    assign full = (count == cnt_w'(rob_depth)) || flush;

    always_comb begin
        count_next = count;
        if (alloc_en) begin
            count_next = count_next + 1'b1;
        end
        if (head_release) begin
            count_next = count_next - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_ptr <= '0;
            count    <= '0;
        end else begin
            count <= count_next;
            if (head_release) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            entries[alloc.tag].op           <= alloc.op;
            entries[alloc.tag].rd           <= alloc.rd;
            entries[alloc.tag].result       <= '0;
            entries[alloc.tag].pred_taken   <= alloc.pred_taken;
            entries[alloc.tag].actual_taken <= 1'b0;
            entries[alloc.tag].next_pc      <= '0;
            entries[alloc.tag].done         <= 1'b0;
        end
        if (alu_done_en) begin
            entries[alu_done.tag].result       <= alu_done.result;
            entries[alu_done.tag].actual_taken <= alu_done.actual_taken;
            entries[alu_done.tag].next_pc      <= alu_done.next_pc;
            entries[alu_done.tag].done         <= 1'b1;
        end
        if (mul_done_en) begin
            entries[mul_done.tag].result       <= mul_done.result;
            entries[mul_done.tag].actual_taken <= mul_done.actual_taken;
            entries[mul_done.tag].next_pc      <= mul_done.next_pc;
            entries[mul_done.tag].done         <= 1'b1;
        end
    end

    // dispatch holds off while the buffer is full or clearing
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (reset)
        alloc_en |-> !full
    );

    a_alu_done_live: assert property (
        @(posedge clk) disable iff (reset)
        alu_done_en |-> occupied(alu_done.tag, head_ptr, count)
    );

    a_mul_done_live: assert property (
        @(posedge clk) disable iff (reset)
        mul_done_en |-> occupied(mul_done.tag, head_ptr, count)
    );

    a_release_ready: assert property (
        @(posedge clk) disable iff (reset)
        head_release |-> (head_valid && head.done)
    );

    // dispatch's tail counter must track head plus occupancy
    a_alloc_at_tail: assert property (
        @(posedge clk) disable iff (reset)
        alloc_en |-> (alloc.tag == rob_tag_t'(head_ptr + count[tag_w-1:0]))
    );

endmodule

//--- logic/retire_unit.sv
`timescale 1ns/1ps

module retire_unit
    import core_pkg::*;
    import rob_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              head_valid,
    input  rob_entry_t        head,
    output logic              head_release,
    output logic              flush,
    output logic [pc_w-1:0]   redirect_pc,
    output logic              retire_en,
    output logic [reg_w-1:0]  retire_rd,
    output logic [data_w-1:0] retire_data,
    output logic              store_en,
    output logic [data_w-1:0] store_data,
    input  logic [reg_w-1:0]  rf_raddr,
    output logic [data_w-1:0] rf_rdata
);

    logic [data_w-1:0] regs [num_regs];
    logic              mispredict;

    // nothing behind a mispredicted branch may retire while flush is out
    assign head_release = head_valid && head.done && !flush;
    assign mispredict   = (head.op == op_branch) && (head.actual_taken != head.pred_taken);

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_en <= 1'b0;
            store_en  <= 1'b0;
            flush     <= 1'b0;
        end else begin
            retire_en <= head_release && is_arith(head.op);
            store_en  <= head_release && (head.op == op_store);
            flush     <= head_release && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (head_release) begin
            retire_rd   <= head.rd;
            retire_data <= head.result;
            store_data  <= head.result;
            redirect_pc <= head.next_pc;
        end
    end

    // architectural register file, cleared at reset, r0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (head_release && is_arith(head.op) && (head.rd != '0)) begin
            regs[head.rd] <= head.result;
        end
    end

    assign rf_rdata = (rf_raddr == '0) ? '0 : regs[rf_raddr];

endmodule

//--- logic/ooo_backend.sv
`timescale 1ns/1ps

module ooo_backend
    import core_pkg::*;
    import rob_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  instr_t            in_instr,
    output logic              full,
    output logic              retire_en,
    output logic [reg_w-1:0]  retire_rd,
    output logic [data_w-1:0] retire_data,
    output logic              store_en,
    output logic [data_w-1:0] store_data,
    output logic              flush,
    output logic [pc_w-1:0]   redirect_pc,
    input  logic [reg_w-1:0]  rf_raddr,
    output logic [data_w-1:0] rf_rdata
);

    logic       alloc_en;
    alloc_t     alloc;
    logic       issue_en;
    issue_t     issue;
    logic       alu_done_en;
    complete_t  alu_done;
    logic       mul_done_en;
    complete_t  mul_done;
    logic       head_valid;
    rob_entry_t head;
    logic       head_release;

    dispatch_unit u_dispatch (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .full     (full),
        .flush    (flush),
        .alloc_en (alloc_en),
        .alloc    (alloc),
        .issue_en (issue_en),
        .issue    (issue)
    );

    exec_unit u_exec (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_en    (issue_en),
        .issue       (issue),
        .alu_done_en (alu_done_en),
        .alu_done    (alu_done),
        .mul_done_en (mul_done_en),
        .mul_done    (mul_done)
    );

    rob u_rob (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .alloc_en     (alloc_en),
        .alloc        (alloc),
        .alu_done_en  (alu_done_en),
        .alu_done     (alu_done),
        .mul_done_en  (mul_done_en),
        .mul_done     (mul_done),
        .head_release (head_release),
        .full         (full),
        .head_valid   (head_valid),
        .head         (head)
    );

    retire_unit u_retire (
        .clk          (clk),
        .reset        (reset),
        .head_valid   (head_valid),
        .head         (head),
        .head_release (head_release),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .retire_en    (retire_en),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .store_en     (store_en),
        .store_data   (store_data),
        .rf_raddr     (rf_raddr),
        .rf_rdata     (rf_rdata)
    );

endmodule

//--- verification/ooo_backend_tb.sv
`timescale 1ns/1ps

module ooo_backend_tb
    import core_pkg::*;
();

    localparam int max_rows     = 64;
    localparam int max_cycles   = 2000;
    localparam int stall_limit  = 64;

    // expected event kinds per table row
    localparam logic [1:0] ev_none   = 2'd0;
    localparam logic [1:0] ev_retire = 2'd1;
    localparam logic [1:0] ev_store  = 2'd2;
    localparam logic [1:0] ev_flush  = 2'd3;

    typedef struct packed {
        instr_t            instr;
        logic [1:0]        kind;
        logic [reg_w-1:0]  rd;
        logic [data_w-1:0] val;
    } row_t;

    logic              clk;
    logic              reset;
    logic              in_valid;
    instr_t            in_instr;
    logic              full;
    logic              retire_en;
    logic [reg_w-1:0]  retire_rd;
    logic [data_w-1:0] retire_data;
    logic              store_en;
    logic [data_w-1:0] store_data;
    logic              flush;
    logic [pc_w-1:0]   redirect_pc;
    logic [reg_w-1:0]  rf_raddr;
    logic [data_w-1:0] rf_rdata;

    row_t              rows [max_rows];
    string             row_test [max_rows];
    logic [data_w-1:0] model_regs [num_regs];
    logic [31:0]       lfsr = 32'h2ebf;
    int                n_rows;
    int                n_nonbranch;
    int                idx;
    int                exp_row;
    int                retired;
    int                stall;

    ooo_backend DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every retire or store pulse out of reset, catches late duplicates too
    always @(posedge clk) begin
        if (!reset && (retire_en || store_en)) begin
            retired++;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else
            fail_run($sformatf("ERROR %s %s: expected %h, actual %h", test, what, exp, act));
    endtask

    task automatic add_row(input string name, input opcode_t op, input logic [31:0] rd,
                           input logic [31:0] a, input logic [31:0] b, input logic pred);
        row_t r;
        r = '0;
        r.instr.op         = op;
        r.instr.rd         = rd[reg_w-1:0];
        r.instr.a          = a;
        r.instr.b          = b;
        r.instr.pc         = 32'h1000 + 32'(n_rows * 4);
        r.instr.target     = 32'h4000 + 32'(n_rows * 32);
        r.instr.pred_taken = pred;
        rows[n_rows]       = r;
        row_test[n_rows]   = name;
        n_rows++;
    endtask

    task automatic build_table();
        opcode_t     pattern [6];
        logic [31:0] v;
        pattern = '{op_mul, op_add, op_sub, op_mul, op_xor, op_add};
        // multiplies ahead of younger alu ops
        for (int i = 0; i < 12; i++) begin
            add_row("arith_order", pattern[i % 6], rand_bits(4), rand_bits(32), rand_bits(32), 0);
        end
        add_row("arith_r0", op_add, 32'd0, rand_bits(32), rand_bits(32), 0);
        add_row("store", op_store, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        add_row("store", op_mul, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        add_row("store", op_store, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        v = rand_bits(32);
        add_row("branch_ok", op_branch, 32'd0, v, v, 1'b1);
        add_row("branch_ok", op_add, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        add_row("branch_ok", op_branch, 32'd0, v, ~v, 1'b0);
        add_row("branch_ok", op_sub, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        // taken but predicted not taken, younger mul in flight
        add_row("mispredict", op_branch, 32'd0, v, v, 1'b0);
        add_row("mispredict", op_mul, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        add_row("mispredict", op_add, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        add_row("mispredict", op_store, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        add_row("mispredict", op_branch, 32'd0, v, v + 1, 1'b1);
        add_row("mispredict", op_xor, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        add_row("mispredict", op_mul, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        for (int i = 0; i < 20; i++) begin
            add_row("mul_burst", op_mul, rand_bits(4), rand_bits(32), rand_bits(32), 0);
        end
        add_row("drain", op_add, rand_bits(4), rand_bits(32), rand_bits(32), 0);
    endtask

    // program-order reference model
    task automatic compute_expected();
        instr_t      ins;
        logic        taken;
        logic [31:0] next_pc;
        for (int r = 0; r < num_regs; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < n_rows; i++) begin
            ins          = rows[i].instr;
            rows[i].rd   = ins.rd;
            rows[i].kind = ev_retire;
            case (ins.op)
                op_add:   rows[i].val = ins.a + ins.b;
                op_sub:   rows[i].val = ins.a - ins.b;
                op_xor:   rows[i].val = ins.a ^ ins.b;
                op_mul:   rows[i].val = ins.a * ins.b;
                op_store: begin
                    rows[i].kind = ev_store;
                    rows[i].val  = ins.a;
                end
                default: begin
                    taken        = (ins.a == ins.b);
                    next_pc      = taken ? ins.target : ins.pc + 32'd4;
                    rows[i].kind = (taken != ins.pred_taken) ? ev_flush : ev_none;
                    rows[i].val  = next_pc;
                end
            endcase
            if (ins.op != op_branch) begin
                n_nonbranch++;
            end
            if (rows[i].kind == ev_retire && ins.rd != '0) begin
                model_regs[ins.rd] = rows[i].val;
            end
        end
    endtask

    // skip rows that produce no observable event
    task automatic next_event();
        while (exp_row < n_rows && rows[exp_row].kind == ev_none) begin
            exp_row++;
        end
    endtask

    task automatic expect_kind(input logic [1:0] k, input string what);
        assert ((exp_row < n_rows) && (rows[exp_row].kind == k)) else
            fail_run($sformatf("unexpected %s event, model expected another at row %0d",
                               what, exp_row));
    endtask

    task automatic check_events();
        string test;
        test = row_test[exp_row];
        if (flush) begin
            expect_kind(ev_flush, "flush");
            check_value(test, "redirect_pc", rows[exp_row].val, redirect_pc);
            // everything dispatched after the branch was dropped
            idx = exp_row + 1;
            exp_row++;
            next_event();
        end else if (retire_en) begin
            expect_kind(ev_retire, "retire");
            check_value(test, "retire_rd", 32'(rows[exp_row].rd), 32'(retire_rd));
            check_value(test, "retire_data", rows[exp_row].val, retire_data);
            exp_row++;
            next_event();
        end else if (store_en) begin
            expect_kind(ev_store, "store");
            check_value(test, "store_data", rows[exp_row].val, store_data);
            exp_row++;
            next_event();
        end
    endtask

    task automatic drive_next();
        if (idx < n_rows) begin
            in_valid = 1'b1;
            in_instr = rows[idx].instr;
            if (full) begin
                stall++;
                if (stall > stall_limit) begin
                    fail_run("timeout waiting for full to drop");
                end
            end else begin
                stall = 0;
                idx++;
            end
        end else begin
            in_valid = 1'b0;
        end
    endtask

    initial begin
        int cyc;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_instr    = '0;
        rf_raddr    = '0;
        n_rows      = 0;
        n_nonbranch = 0;
        idx         = 0;
        exp_row     = 0;
        retired     = 0;
        stall       = 0;
        cyc         = 0;
        build_table();
        compute_expected();
        next_event();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // outputs are quiet straight out of reset
        check_value("reset_state", "full", 32'd0, 32'(full));
        check_value("reset_state", "retire_en", 32'd0, 32'(retire_en));
        check_value("reset_state", "store_en", 32'd0, 32'(store_en));
        check_value("reset_state", "flush", 32'd0, 32'(flush));

        while (!(exp_row >= n_rows && idx >= n_rows) && cyc < max_cycles) begin
            @(negedge clk);
            cyc++;
            check_events();
            drive_next();
        end
        in_valid = 1'b0;
        if (exp_row < n_rows || idx < n_rows) begin
            fail_run("timeout waiting for the buffer to drain");
        end

        // architectural state through the read port
        for (int r = 0; r < num_regs; r++) begin
            @(negedge clk);
            rf_raddr = reg_w'(r);
            @(posedge clk);
            check_value("final_regs", $sformatf("r%0d", r), model_regs[r], rf_rdata);
        end

        @(negedge clk);
        if (retired == n_nonbranch) begin
            $display("** PASS **");
            $finish;
        end else begin
            fail_run($sformatf("ERROR back_pressure retire_count: expected %0d, actual %0d",
                               n_nonbranch, retired));
        end
    end

endmodule

//--- ooo_backend.f
logic/core_pkg.sv
logic/rob_pkg.sv
logic/dispatch_unit.sv
logic/exec_unit.sv
logic/rob.sv
logic/retire_unit.sv
logic/ooo_backend.sv
verification/ooo_backend_tb.sv
